/* src/b14_macros.svh */
// Instruction set constants; addresses wrap at 2^20 words and bit 31 of an instruction is ignored
`ifndef B14_MACROS_SVH
`define B14_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data path widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define B14_DATA_BITS 32
`define B14_ADDR_BITS 20

// Add and subtract keep only this many low bits
`define B14_RESULT_BITS 30

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter and register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// reg3 is cut to this width before the step is added
`define B14_PC_WRAP_BITS 29
`define B14_PC_STEP 8
`define B14_NUM_REGS 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction field values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define B14_STORE_DEST 7

// Operate functions from this value up do nothing and read no memory
`define B14_FIRST_NOP_FUNC 12

`endif

/* src/b14_pkg.sv */
// Shared types of the core; the instruction layout assumes 32-bit words with a 20-bit tail
`include "b14_macros.svh"

package b14_pkg;

   typedef logic [`B14_DATA_BITS-1:0] word_t;
   typedef logic [`B14_ADDR_BITS-1:0] addr_t;
   typedef logic [1:0]                reg_sel_t;

   typedef enum logic [1:0]
   {
      state_fetch,
      state_decode,
      state_execute
   } cpu_state_e;

   // Field view used for decoding the operation
   typedef struct packed {
      logic        unused;
      reg_sel_t    src_sel;
      logic [1:0]  mode;
      logic [2:0]  dest_field;
      logic        is_compare;
      logic [3:0]  func;
      logic [18:0] low;
   } op_view_t;

   // The tail of the address view shares bit 19 with the low bit of func
   typedef struct packed {
      logic [11:0] upper;
      addr_t       tail;
   } addr_view_t;

   typedef union packed {
      op_view_t   op_view;
      addr_view_t addr_view;
   } instr_u;

   typedef struct packed {
      logic   exec;
      instr_u instr;
      logic   is_store;
      logic   uses_mem;
   } exec_ctrl_t;

   typedef struct packed {
      word_t value;
      logic  flag_next;
      logic  flag_write;
      logic  reg_write;
      logic  swap;
   } alu_result_t;

endpackage

/* src/b14_sequencer.sv */
// Three cycles per instruction with no wait states; the memory must answer datai in the same cycle
`timescale 1ns/1ps
`include "b14_macros.svh"

module b14_sequencer
   import b14_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  word_t      datai,
   input  word_t      pc,
   input  addr_t      eff_addr,
   input  word_t      store_data,
   output exec_ctrl_t ctrl,
   output addr_t      addr,
   output logic       rd,
   output logic       wr,
   output word_t      datao
);

   cpu_state_e state;
   instr_u     ir;
   instr_u     cur_instr;
   logic       is_store;
   logic       uses_mem;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Decode
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // The fetched word sits on datai during decode, before the IR has it
   always_comb
   begin
      cur_instr = ir;
      if (state == state_decode)
      begin
         cur_instr = datai;
      end
   end

   always_comb
   begin
      is_store = !cur_instr.op_view.is_compare &&
                 (cur_instr.op_view.dest_field == 3'(`B14_STORE_DEST));
      uses_mem = (cur_instr.op_view.mode != 2'd0) && !is_store &&
                 (cur_instr.op_view.is_compare ||
                  (cur_instr.op_view.func < 4'(`B14_FIRST_NOP_FUNC)));
   end

   always_comb
   begin
      ctrl.exec     = (state == state_execute);
      ctrl.instr    = cur_instr;
      ctrl.is_store = is_store;
      ctrl.uses_mem = uses_mem;
   end

   always_ff @(posedge clock)
   begin
      if (state == state_decode)
      begin
         ir <= datai;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // State and bus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Bus outputs are registered, so each access shows one cycle after its state
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state <= state_fetch;
         addr  <= '0;
         rd    <= 1'b0;
         wr    <= 1'b0;
         datao <= '0;
      end
      else
      begin
         rd <= 1'b0;
         wr <= 1'b0;
         case (state)
            state_fetch:
            begin
               addr  <= pc[`B14_ADDR_BITS-1:0];
               rd    <= 1'b1;
               state <= state_decode;
            end
            state_decode:
            begin
               if (uses_mem)
               begin
                  addr <= eff_addr;
                  rd   <= 1'b1;
               end
               state <= state_execute;
            end
            state_execute:
            begin
               if (is_store)
               begin
                  addr  <= eff_addr;
                  wr    <= 1'b1;
                  datao <= store_data;
               end
               state <= state_fetch;
            end
            default:
            begin
               state <= state_fetch;
            end
         endcase
      end
   end

endmodule

/* src/b14_operand.sv */
// Combinational; the operand is only valid in execute, when datai holds the word read in decode
`timescale 1ns/1ps
`include "b14_macros.svh"

module b14_operand
   import b14_pkg::*;
(
   input  exec_ctrl_t ctrl,
   input  word_t      datai,
   input  word_t      reg1,
   input  word_t      reg2,
   output addr_t      eff_addr,
   output word_t      operand
);

   addr_t tail;

   assign tail = ctrl.instr.addr_view.tail;

   // Indexed modes add the low address bits of reg1 or reg2 and wrap at 2^20
   always_comb
   begin
      case (ctrl.instr.op_view.mode)
         2'd2:
         begin
            eff_addr = tail + reg1[`B14_ADDR_BITS-1:0];
         end
         2'd3:
         begin
            eff_addr = tail + reg2[`B14_ADDR_BITS-1:0];
         end
         default:
         begin
            eff_addr = tail;
         end
      endcase
   end

   // Immediate mode and instructions without a memory read take the tail
   always_comb
   begin
      if (ctrl.uses_mem)
      begin
         operand = datai;
      end
      else
      begin
         operand = word_t'(tail);
      end
   end

endmodule

/* src/b14_alu.sv */
// Signed compares and 30-bit add/subtract; write strobes are only raised in execute
`timescale 1ns/1ps
`include "b14_macros.svh"

module b14_alu
   import b14_pkg::*;
(
   input  exec_ctrl_t  ctrl,
   input  word_t       src_value,
   input  word_t       operand,
   input  logic        flag,
   output alu_result_t result
);

   localparam logic signed [`B14_DATA_BITS-1:0] wrap_base = 1 << `B14_RESULT_BITS;

   logic signed [`B14_DATA_BITS-1:0] r_s;
   logic signed [`B14_DATA_BITS-1:0] m_s;
   logic signed [`B14_DATA_BITS-1:0] r_wrap;
   logic       cond;
   logic       op_exec;
   logic [3:0] func;
   word_t      sum;
   word_t      diff;

   assign func    = ctrl.instr.op_view.func;
   assign op_exec = ctrl.exec && !ctrl.instr.op_view.is_compare && !ctrl.is_store;
   assign sum     = src_value + operand;
   assign diff    = src_value - operand;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Compare group
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb
   begin
      r_s = src_value;
      m_s = operand;
      // Conditions 6 and 7 fold r back below 2^30 first
      r_wrap = (r_s >= wrap_base) ? (r_s - wrap_base) : r_s;
      case (func[2:0])
         3'd0: cond = (r_s < m_s);
         3'd1: cond = !(r_s < m_s);
         3'd2: cond = (r_s == m_s);
         3'd3: cond = (r_s != m_s);
         3'd4: cond = !(r_s > m_s);
         3'd5: cond = (r_s > m_s);
         3'd6: cond = (r_wrap < m_s);
         default: cond = !(r_wrap < m_s);
      endcase
   end

   // Upper eight conditions accumulate into the old flag
   assign result.flag_next  = cond || (func[3] && flag);
   assign result.flag_write = ctrl.exec && ctrl.instr.op_view.is_compare;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Operate group
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb
   begin
      result.value     = operand;
      result.reg_write = 1'b0;
      result.swap      = 1'b0;
      case (func)
         4'd0:
         begin
            result.value     = '0 - operand;
            result.reg_write = op_exec;
         end
         4'd1:
         begin
            result.swap = op_exec;
         end
         4'd2, 4'd3:
         begin
            result.reg_write = op_exec;
         end
         4'd4, 4'd5, 4'd8, 4'd10:
         begin
            result.value     = word_t'(sum[`B14_RESULT_BITS-1:0]);
            result.reg_write = op_exec;
         end
         4'd6, 4'd7, 4'd9, 4'd11:
         begin
            result.value     = word_t'(diff[`B14_RESULT_BITS-1:0]);
            result.reg_write = op_exec;
         end
         default:
         begin
            // The former shift group writes nothing
         end
      endcase
   end

endmodule

/* src/b14_regfile.sv */
// reg3 is the program counter and steps by 8 every executed instruction unless it is written
`timescale 1ns/1ps
`include "b14_macros.svh"

module b14_regfile
   import b14_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  exec_ctrl_t  ctrl,
   input  alu_result_t result,
   output word_t       src_value,
   output word_t       reg1,
   output word_t       reg2,
   output word_t       pc,
   output logic        flag
);

   word_t    regs [`B14_NUM_REGS];
   word_t    pc_step;
   reg_sel_t src_sel;
   reg_sel_t dest;
   reg_sel_t dest_next;
   logic     dest_update;

   assign pc_step = word_t'(regs[3][`B14_PC_WRAP_BITS-1:0]) + word_t'(`B14_PC_STEP);
   assign src_sel = ctrl.instr.op_view.src_sel;

   // A source of reg3 already sees the stepped counter
   assign src_value = (src_sel == 2'd3) ? pc_step : regs[src_sel];

   assign reg1 = regs[1];
   assign reg2 = regs[2];
   assign pc   = regs[3];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Sticky destination
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Fields 4 and 5 branch through reg3, and a failed condition keeps the old dest
   always_comb
   begin
      dest_next = dest;
      case (ctrl.instr.op_view.dest_field)
         3'd0, 3'd1, 3'd2, 3'd3:
         begin
            dest_next = ctrl.instr.op_view.dest_field[1:0];
         end
         3'd4:
         begin
            if (flag)
            begin
               dest_next = 2'd3;
            end
         end
         3'd5:
         begin
            if (!flag)
            begin
               dest_next = 2'd3;
            end
         end
         default:
         begin
         end
      endcase
   end

   assign dest_update = ctrl.exec && !ctrl.instr.op_view.is_compare && !ctrl.is_store;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int i = 0; i < `B14_NUM_REGS; i++)
         begin
            regs[i] <= '0;
         end
         dest <= '0;
         flag <= 1'b0;
      end
      else
      begin
         if (ctrl.exec)
         begin
            regs[3] <= pc_step;
         end
         if (dest_update)
         begin
            dest <= dest_next;
         end
         if (result.flag_write)
         begin
            flag <= result.flag_next;
         end
         // Move-and-swap ignores dest
         if (result.swap)
         begin
            regs[2] <= pc_step;
            regs[3] <= result.value;
         end
         else if (result.reg_write)
         begin
            regs[dest_next] <= result.value;
         end
      end
   end

endmodule

/* src/b14_cpu.sv */
// Top of the core; expects a combinational memory and never stalls
`timescale 1ns/1ps

module b14_cpu
   import b14_pkg::*;
(
   input  logic  clock,
   input  logic  reset,
   output addr_t addr,
   input  word_t datai,
   output word_t datao,
   output logic  rd,
   output logic  wr
);

   exec_ctrl_t  ctrl;
   alu_result_t result;
   word_t       src_value;
   word_t       reg1;
   word_t       reg2;
   word_t       pc;
   word_t       operand;
   addr_t       eff_addr;
   logic        flag;

   b14_sequencer u_sequencer (
      .clock      (clock),
      .reset      (reset),
      .datai      (datai),
      .pc         (pc),
      .eff_addr   (eff_addr),
      .store_data (src_value),
      .ctrl       (ctrl),
      .addr       (addr),
      .rd         (rd),
      .wr         (wr),
      .datao      (datao)
   );

   b14_operand u_operand (
      .ctrl     (ctrl),
      .datai    (datai),
      .reg1     (reg1),
      .reg2     (reg2),
      .eff_addr (eff_addr),
      .operand  (operand)
   );

   b14_alu u_alu (
      .ctrl      (ctrl),
      .src_value (src_value),
      .operand   (operand),
      .flag      (flag),
      .result    (result)
   );

   b14_regfile u_regfile (
      .clock     (clock),
      .reset     (reset),
      .ctrl      (ctrl),
      .result    (result),
      .src_value (src_value),
      .reg1      (reg1),
      .reg2      (reg2),
      .pc        (pc),
      .flag      (flag)
   );

endmodule

/* tests/b14_cpu_properties.sv */
// Bus strobe rules for b14_cpu; assumes rd and wr are registered and cleared by a synchronous reset
`timescale 1ns/1ps

module b14_cpu_properties
(
   input logic clock,
   input logic reset,
   input logic rd,
   input logic wr
);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bus strobes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Reads and writes share one address bus
   strobes_exclusive : assert property (
      @(posedge clock) disable iff (reset) !(rd && wr)
   )
   else
      $error("rd and wr are high in the same cycle");

   // A store shows only in the cycle after execute and never twice in a row
   single_write : assert property (
      @(posedge clock) disable iff (reset) wr |=> !wr
   )
   else
      $error("wr stayed high for two cycles in a row");

   quiet_after_reset : assert property (
      @(posedge clock) reset |=> (!rd && !wr)
   )
   else
      $error("rd or wr is high in the first cycle after reset");

endmodule

/* tests/tb_b14_cpu.sv */
// Memory is read-only to the core; stores are checked on the bus but never written back
`timescale 1ns/1ps
`include "b14_macros.svh"

module tb_b14_cpu
   import b14_pkg::*;
();

   localparam int num_instr   = 2000;
   localparam int cycle_limit = 3 * num_instr + 50;
   localparam int mem_words   = 1 << `B14_ADDR_BITS;
   localparam logic signed [31:0] wrap_limit = 32'sh4000_0000;

   logic     clock;
   logic     reset;
   addr_t    addr;
   word_t    datai;
   word_t    datao;
   logic     rd;
   logic     wr;

   word_t    mem [mem_words];

   // Reference model state
   word_t    model_regs [`B14_NUM_REGS];
   logic     model_flag;
   reg_sel_t model_dest;

   int       errors;
   int       checks;
   int       cycles;

   b14_cpu DUT (
      .clock (clock),
      .reset (reset),
      .addr  (addr),
      .datai (datai),
      .datao (datao),
      .rd    (rd),
      .wr    (wr)
   );

   bind b14_cpu b14_cpu_properties u_properties (
      .clock (clock),
      .reset (reset),
      .rd    (rd),
      .wr    (wr)
   );

   assign datai = mem[addr];

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   function automatic word_t xorshift(input word_t x);
      word_t y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic compare_word(input string what, input word_t got, input word_t exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic require_true(input logic ok, input string what);
      checks++;
      assert (ok)
      else
      begin
         errors++;
         $display("At %0t the %s", $time, what);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model of one instruction over its three bus cycles
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic step_instruction(input int n);
      word_t      w;
      word_t      pc_step;
      word_t      r;
      word_t      m;
      word_t      value;
      addr_t      pc_addr;
      addr_t      tail;
      addr_t      eff;
      reg_sel_t   src_sel;
      reg_sel_t   dest_next;
      logic [1:0] mode;
      logic [2:0] dest_field;
      logic [3:0] func;
      logic       is_compare;
      logic       is_store;
      logic       uses_mem;
      logic       write_en;
      logic       cond;
      logic signed [31:0] rs;
      logic signed [31:0] ms;
      logic signed [31:0] rw;

      @(negedge clock);
      while (rd !== 1'b1)
      begin
         @(negedge clock);
      end
      require_true(cycles == 3 * n + 1, "fetch strobe is not three cycles after the last one");
      pc_addr = model_regs[3][`B14_ADDR_BITS-1:0];
      compare_word("fetch addr", word_t'(addr), word_t'(pc_addr));

      w          = mem[pc_addr];
      src_sel    = w[30:29];
      mode       = w[28:27];
      dest_field = w[26:24];
      is_compare = w[23];
      func       = w[22:19];
      tail       = w[19:0];

      pc_step = (model_regs[3] % (32'd1 << `B14_PC_WRAP_BITS)) + `B14_PC_STEP;
      r       = (src_sel == 2'd3) ? pc_step : model_regs[src_sel];
      case (mode)
         2'd2: eff = tail + model_regs[1][`B14_ADDR_BITS-1:0];
         2'd3: eff = tail + model_regs[2][`B14_ADDR_BITS-1:0];
         default: eff = tail;
      endcase
      is_store = !is_compare && (dest_field == 3'd7);
      uses_mem = (mode != 2'd0) && !is_store && (is_compare || func < 4'd12);

      // The decode cycle reads an operand only when the instruction needs memory
      @(negedge clock);
      compare_word("operand rd", word_t'(rd), word_t'(uses_mem));
      compare_word("wr in decode", word_t'(wr), 32'd0);
      if (uses_mem)
      begin
         compare_word("operand addr", word_t'(addr), word_t'(eff));
      end
      m = uses_mem ? mem[eff] : {12'd0, tail};

      model_regs[3] = pc_step;
      if (is_compare)
      begin
         rs = r;
         ms = m;
         rw = (rs >= wrap_limit) ? rs - wrap_limit : rs;
         case (func[2:0])
            3'd0: cond = rs < ms;
            3'd1: cond = rs >= ms;
            3'd2: cond = rs == ms;
            3'd3: cond = rs != ms;
            3'd4: cond = rs <= ms;
            3'd5: cond = rs > ms;
            3'd6: cond = rw < ms;
            default: cond = rw >= ms;
         endcase
         model_flag = cond || (func[3] && model_flag);
      end
      else if (!is_store)
      begin
         dest_next = model_dest;
         if (dest_field <= 3'd3)
            dest_next = dest_field[1:0];
         else if (dest_field == 3'd4 && model_flag)
            dest_next = 2'd3;
         else if (dest_field == 3'd5 && !model_flag)
            dest_next = 2'd3;
         model_dest = dest_next;

         write_en = 1'b1;
         value    = m;
         case (func)
            4'd0: value = 32'd0 - m;
            4'd4, 4'd5, 4'd8, 4'd10: value = {2'b00, r[29:0] + m[29:0]};
            4'd6, 4'd7, 4'd9, 4'd11: value = {2'b00, r[29:0] - m[29:0]};
            4'd1, 4'd2, 4'd3: value = m;
            default: write_en = 1'b0;
         endcase
         if (func == 4'd1)
         begin
            model_regs[2] = pc_step;
            model_regs[3] = m;
         end
         else if (write_en)
         begin
            model_regs[dest_next] = value;
         end
      end

      // The cycle after execute carries the store with the source register as data
      @(negedge clock);
      compare_word("store wr", word_t'(wr), word_t'(is_store));
      compare_word("rd after execute", word_t'(rd), 32'd0);
      if (is_store)
      begin
         compare_word("store addr", word_t'(addr), word_t'(eff));
         compare_word("store datao", datao, r);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Run control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial
   begin
      cycles = 0;
      @(negedge reset);
      while (cycles < cycle_limit)
      begin
         @(posedge clock);
         cycles++;
      end
      $display("Timeout after %0d cycles with %0d errors in %0d checks", cycles, errors,
               checks);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      word_t seed;

      reset  = 1'b1;
      errors = 0;
      checks = 0;

      // Random program and data are mixed with the address so every word differs
      seed = 32'd51730;
      for (int a = 0; a < mem_words; a++)
      begin
         seed   = xorshift(seed);
         mem[a] = seed ^ word_t'(a);
      end

      for (int i = 0; i < `B14_NUM_REGS; i++)
      begin
         model_regs[i] = '0;
      end
      model_flag = 1'b0;
      model_dest = '0;

      repeat (4) @(posedge clock);
      #1 reset = 1'b0;

      for (int n = 0; n < num_instr; n++)
      begin
         step_instruction(n);
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* b14_cpu.f */
+incdir+src
src/b14_pkg.sv
src/b14_sequencer.sv
src/b14_operand.sv
src/b14_alu.sv
src/b14_regfile.sv
src/b14_cpu.sv
tests/b14_cpu_properties.sv
tests/tb_b14_cpu.sv

/* Makefile */
# Verilator build and run of the b14 core testbench

VERILATOR ?= verilator
TOP       ?= tb_b14_cpu
FILELIST  ?= b14_cpu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
